// File: tb.f
hw/gw_boot_pkg.sv
hw/gw_msg_pkg.sv
hw/gw_skid_buffer.sv
hw/gw_cfg_loader.sv
hw/gw_nbf_loader.sv
hw/gw_load_arbiter.sv
hw/gw_boot_top.sv
testbench/tb_gw_boot.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_gw_boot
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_gw_boot.sv
`timescale 1ns/1ps

module tb_gw_boot
  import gw_boot_pkg::*;
  import gw_msg_pkg::*;
();

  localparam int unsigned max_words = 30;

  logic                     p_clk_i;
  logic                     rst_n_i;
  logic                     nbf_valid_i;
  logic [gw_data_width-1:0] nbf_data_i;
  logic                     nbf_last_i;
  logic                     nbf_ready_o;
  logic                     mem_cmd_valid_o;
  gw_mem_cmd_s              mem_cmd_o;
  logic                     mem_cmd_ready_i;
  logic                     mem_resp_valid_i;
  gw_mem_resp_s             mem_resp_i;
  logic                     mem_resp_ready_o;
  logic                     done_o;

  logic [gw_data_width-1:0] words [max_words];
  int unsigned              gaps [max_words];
  int unsigned              num_words;
  bit                       words_ready;
  gw_mem_cmd_s              exp_q [$];
  gw_mem_resp_s             pend_resp_q [$];
  int unsigned              pend_due_q [$];
  int unsigned              cycle_cnt;
  int unsigned              cmd_count;
  int unsigned              resp_count;
  int unsigned              check_count;
  int unsigned              error_count;
  int                       in_flight;
  bit                       cmd_fire;
  bit                       resp_fire;
  bit                       nbf_fire;
  bit                       done_prev;
  gw_mem_cmd_s              seen_cmd;
  int unsigned              word_idx;
  int unsigned              gap_left;

  gw_boot_top dut0
  (
    .p_clk_i          (p_clk_i),
    .rst_n_i          (rst_n_i),
    .nbf_valid_i      (nbf_valid_i),
    .nbf_data_i       (nbf_data_i),
    .nbf_last_i       (nbf_last_i),
    .nbf_ready_o      (nbf_ready_o),
    .mem_cmd_valid_o  (mem_cmd_valid_o),
    .mem_cmd_o        (mem_cmd_o),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_i       (mem_resp_i),
    .mem_resp_ready_o (mem_resp_ready_o),
    .done_o           (done_o)
  );

  always #2 p_clk_i = ~p_clk_i;

  ////////////////////////////////////////////////////////////
  // Reference model and reporting

  // Config table first, then program words from the memory base
  function automatic gw_mem_cmd_s expected_cmd(input int unsigned pos,
                                               input logic [gw_data_width-1:0] word);
    gw_mem_cmd_s cmd;
    cmd.op = gw_op_write;
    if (pos < gw_cfg_entries)
    begin
      cmd.addr = gw_cfg_base + gw_addr_width'(pos * gw_word_bytes);
      cmd.data = gw_cfg_rom[pos];
    end
    else
    begin
      cmd.addr = gw_mem_base + gw_addr_width'((pos - gw_cfg_entries) * gw_word_bytes);
      cmd.data = word;
    end
    return cmd;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    error_count++;
    $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("At %0d ns: %s", $time, what);
  endtask

  task automatic check_cmd(input gw_mem_cmd_s got);
    gw_mem_cmd_s exp;
    assert (exp_q.size() != 0)
      else report_failure("memory command seen after the last expected one");
    if (exp_q.size() != 0)
    begin
      exp = exp_q.pop_front();
      check_count++;
      assert (got.op == exp.op)
        else report_mismatch("mem_cmd_o.op", 64'(got.op), 64'(exp.op));
      assert (got.addr == exp.addr)
        else report_mismatch("mem_cmd_o.addr", 64'(got.addr), 64'(exp.addr));
      assert (got.data == exp.data)
        else report_mismatch("mem_cmd_o.data", got.data, exp.data);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor and checker at the rising edge

  always @(posedge p_clk_i)
  begin
    cmd_fire  = rst_n_i && mem_cmd_valid_o && mem_cmd_ready_i;
    resp_fire = rst_n_i && mem_resp_valid_i && mem_resp_ready_o;
    nbf_fire  = rst_n_i && nbf_valid_i && nbf_ready_o;
    if (rst_n_i)
    begin
      cycle_cnt++;
      if (cmd_fire)
      begin
        seen_cmd = mem_cmd_o;
        check_cmd(seen_cmd);
        cmd_count++;
      end
      if (resp_fire)
      begin
        resp_count++;
      end
      in_flight = int'(cmd_count) - int'(resp_count);
      assert (in_flight <= int'(2 * gw_max_outstanding))
        else report_failure("too many commands accepted without a response");
      if (nbf_ready_o)
        assert (resp_count >= gw_cfg_entries)
          else report_failure("nbf_ready_o rose before all config responses were sent");
      if (done_o && !done_prev)
        assert (resp_count == gw_cfg_entries + num_words)
          else report_failure("done_o rose before the last program write was answered");
      assert (!(done_prev && !done_o))
        else report_failure("done_o fell after it was raised");
      done_prev = done_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus on the falling edge

  // Memory model, in-order answers after a random delay
  task automatic drive_memory();
    gw_mem_resp_s resp;
    if (resp_fire)
    begin
      void'(pend_resp_q.pop_front());
      void'(pend_due_q.pop_front());
    end
    if (cmd_fire)
    begin
      resp.op   = seen_cmd.op;
      resp.addr = seen_cmd.addr;
      pend_resp_q.push_back(resp);
      pend_due_q.push_back(cycle_cnt + $urandom_range(1, 5));
    end
    mem_cmd_ready_i = ($urandom_range(0, 3) != 0);
    if (pend_resp_q.size() != 0 && pend_due_q[0] <= cycle_cnt)
    begin
      mem_resp_valid_i = 1'b1;
      mem_resp_i       = pend_resp_q[0];
    end
    else
    begin
      mem_resp_valid_i = 1'b0;
      mem_resp_i       = '0;
    end
  endtask

  task automatic drive_nbf();
    if (nbf_fire)
    begin
      word_idx++;
      nbf_valid_i = 1'b0;
      nbf_last_i  = 1'b0;
      if (word_idx < num_words)
      begin
        gap_left = gaps[word_idx];
      end
    end
    if (!nbf_valid_i && word_idx < num_words)
    begin
      if (gap_left > 0)
      begin
        gap_left--;
      end
      else
      begin
        nbf_valid_i = 1'b1;
        nbf_data_i  = words[word_idx];
        nbf_last_i  = (word_idx == num_words - 1);
      end
    end
  endtask

  initial
  begin
    logic [gw_data_width-1:0] word;
    int unsigned              k;
    p_clk_i          = 1'b0;
    rst_n_i          = 1'b0;
    nbf_valid_i      = 1'b0;
    nbf_data_i       = '0;
    nbf_last_i       = 1'b0;
    mem_cmd_ready_i  = 1'b0;
    mem_resp_valid_i = 1'b0;
    mem_resp_i       = '0;
    void'($urandom(32'h854c_2994));
    num_words = $urandom_range(10, 30);
    for (k = 0; k < num_words; k++)
    begin
      words[k] = {$urandom, $urandom};
      gaps[k]  = $urandom_range(0, 3);
    end
    for (k = 0; k < gw_cfg_entries + num_words; k++)
    begin
      word = '0;
      if (k >= gw_cfg_entries)
      begin
        word = words[k - gw_cfg_entries];
      end
      exp_q.push_back(expected_cmd(k, word));
    end
    words_ready = 1'b1;
    word_idx    = 0;
    gap_left    = gaps[0];

    repeat (3) @(posedge p_clk_i);
    @(negedge p_clk_i);
    assert (!mem_cmd_valid_o && !nbf_ready_o && !done_o)
      else report_failure("outputs were not low in reset");
    rst_n_i = 1'b1;

    while (!done_o)
    begin
      @(negedge p_clk_i);
      drive_memory();
      drive_nbf();
    end
    // Let stray commands show up
    repeat (10)
    begin
      @(negedge p_clk_i);
      drive_memory();
    end

    assert (cmd_count == gw_cfg_entries + num_words)
      else report_failure($sformatf("%0d commands seen, %0d expected",
                                    cmd_count, gw_cfg_entries + num_words));
    assert (pend_resp_q.size() == 0)
      else report_failure("commands were left without a response");
    $display("Commands: %0d, checks: %0d, errors: %0d", cmd_count, check_count, error_count);
    if (error_count == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    wait (words_ready);
    repeat (200 + 20 * num_words) @(posedge p_clk_i);
    report_failure("timeout, done_o never rose");
    $display("Commands: %0d, checks: %0d, errors: %0d", cmd_count, check_count, error_count);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: hw/gw_boot_top.sv
`timescale 1ns/1ps

module gw_boot_top
  import gw_boot_pkg::*;
  import gw_msg_pkg::*;
(
  input  logic                     p_clk_i,
  input  logic                     rst_n_i,
  input  logic                     nbf_valid_i,
  input  logic [gw_data_width-1:0] nbf_data_i,
  input  logic                     nbf_last_i,
  output logic                     nbf_ready_o,
  output logic                     mem_cmd_valid_o,
  output gw_mem_cmd_s              mem_cmd_o,
  input  logic                     mem_cmd_ready_i,
  input  logic                     mem_resp_valid_i,
  input  gw_mem_resp_s             mem_resp_i,
  output logic                     mem_resp_ready_o,
  output logic                     done_o
);

  logic         cfg_done;
  logic         cfg_cmd_valid;
  gw_mem_cmd_s  cfg_cmd;
  logic         cfg_cmd_ready;
  logic         cfg_resp_valid;
  gw_mem_resp_s cfg_resp;
  logic         cfg_resp_ready;
  logic         nbf_cmd_valid;
  gw_mem_cmd_s  nbf_cmd;
  logic         nbf_cmd_ready;
  logic         nbf_resp_valid;
  gw_mem_resp_s nbf_resp;
  logic         nbf_resp_ready;

  gw_cfg_loader cfg_loader
  (
    .p_clk_i      (p_clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_valid_o  (cfg_cmd_valid),
    .cmd_o        (cfg_cmd),
    .cmd_ready_i  (cfg_cmd_ready),
    .resp_valid_i (cfg_resp_valid),
    .resp_i       (cfg_resp),
    .resp_ready_o (cfg_resp_ready),
    .cfg_done_o   (cfg_done)
  );

  gw_nbf_loader nbf_loader
  (
    .p_clk_i      (p_clk_i),
    .rst_n_i      (rst_n_i),
    .nbf_valid_i  (nbf_valid_i),
    .nbf_data_i   (nbf_data_i),
    .nbf_last_i   (nbf_last_i),
    .nbf_ready_o  (nbf_ready_o),
    .cmd_valid_o  (nbf_cmd_valid),
    .cmd_o        (nbf_cmd),
    .cmd_ready_i  (nbf_cmd_ready),
    .resp_valid_i (nbf_resp_valid),
    .resp_i       (nbf_resp),
    .resp_ready_o (nbf_resp_ready),
    .done_o       (done_o)
  );

  ////////////////////////////////////////////////////////////
  // One memory channel shared by both loaders

  gw_load_arbiter load_arb
  (
    .p_clk_i          (p_clk_i),
    .rst_n_i          (rst_n_i),
    .cfg_done_i       (cfg_done),
    .cfg_cmd_valid_i  (cfg_cmd_valid),
    .cfg_cmd_i        (cfg_cmd),
    .cfg_cmd_ready_o  (cfg_cmd_ready),
    .cfg_resp_valid_o (cfg_resp_valid),
    .cfg_resp_o       (cfg_resp),
    .cfg_resp_ready_i (cfg_resp_ready),
    .nbf_cmd_valid_i  (nbf_cmd_valid),
    .nbf_cmd_i        (nbf_cmd),
    .nbf_cmd_ready_o  (nbf_cmd_ready),
    .nbf_resp_valid_o (nbf_resp_valid),
    .nbf_resp_o       (nbf_resp),
    .nbf_resp_ready_i (nbf_resp_ready),
    .mem_cmd_valid_o  (mem_cmd_valid_o),
    .mem_cmd_o        (mem_cmd_o),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_i       (mem_resp_i),
    .mem_resp_ready_o (mem_resp_ready_o)
  );

endmodule

// File: hw/gw_load_arbiter.sv
`timescale 1ns/1ps

module gw_load_arbiter
  import gw_msg_pkg::*;
(
  input  logic         p_clk_i,
  input  logic         rst_n_i,
  input  logic         cfg_done_i,
  input  logic         cfg_cmd_valid_i,
  input  gw_mem_cmd_s  cfg_cmd_i,
  output logic         cfg_cmd_ready_o,
  output logic         cfg_resp_valid_o,
  output gw_mem_resp_s cfg_resp_o,
  input  logic         cfg_resp_ready_i,
  input  logic         nbf_cmd_valid_i,
  input  gw_mem_cmd_s  nbf_cmd_i,
  output logic         nbf_cmd_ready_o,
  output logic         nbf_resp_valid_o,
  output gw_mem_resp_s nbf_resp_o,
  input  logic         nbf_resp_ready_i,
  output logic         mem_cmd_valid_o,
  output gw_mem_cmd_s  mem_cmd_o,
  input  logic         mem_cmd_ready_i,
  input  logic         mem_resp_valid_i,
  input  gw_mem_resp_s mem_resp_i,
  output logic         mem_resp_ready_o
);

  logic         sel_cmd_valid;
  gw_mem_cmd_s  sel_cmd;
  logic         cmd_in_ready;
  logic         resp_out_valid;
  gw_mem_resp_s resp_out;
  logic         resp_out_ready;

  ////////////////////////////////////////////////////////////
  // Command path, phase owner only

  assign sel_cmd_valid   = cfg_done_i ? nbf_cmd_valid_i : cfg_cmd_valid_i;
  assign sel_cmd         = cfg_done_i ? nbf_cmd_i : cfg_cmd_i;
  assign cfg_cmd_ready_o = cmd_in_ready & ~cfg_done_i;
  assign nbf_cmd_ready_o = cmd_in_ready & cfg_done_i;

  gw_skid_buffer #(.payload_t(gw_mem_cmd_s)) cmd_buf
  (
    .p_clk_i     (p_clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (sel_cmd_valid),
    .in_data_i   (sel_cmd),
    .in_ready_o  (cmd_in_ready),
    .out_valid_o (mem_cmd_valid_o),
    .out_data_o  (mem_cmd_o),
    .out_ready_i (mem_cmd_ready_i)
  );

  ////////////////////////////////////////////////////////////
  // Response path

  gw_skid_buffer #(.payload_t(gw_mem_resp_s)) resp_buf
  (
    .p_clk_i     (p_clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (mem_resp_valid_i),
    .in_data_i   (mem_resp_i),
    .in_ready_o  (mem_resp_ready_o),
    .out_valid_o (resp_out_valid),
    .out_data_o  (resp_out),
    .out_ready_i (resp_out_ready)
  );

  // Steer to whichever loader owns the phase
  assign cfg_resp_valid_o = resp_out_valid & ~cfg_done_i;
  assign nbf_resp_valid_o = resp_out_valid & cfg_done_i;
  assign cfg_resp_o       = resp_out;
  assign nbf_resp_o       = resp_out;
  assign resp_out_ready   = cfg_done_i ? nbf_resp_ready_i : cfg_resp_ready_i;

  // Program phase opens only once the config loader has nothing left to send
  a_nbf_after_cfg: assert property (@(posedge p_clk_i) disable iff (!rst_n_i)
    nbf_cmd_valid_i && nbf_cmd_ready_o |-> !cfg_cmd_valid_i);

  a_phase_hold: assert property (@(posedge p_clk_i) disable iff (!rst_n_i)
    cfg_done_i |=> cfg_done_i);

endmodule

// File: hw/gw_nbf_loader.sv
`timescale 1ns/1ps

module gw_nbf_loader
  import gw_boot_pkg::*;
  import gw_msg_pkg::*;
(
  input  logic                     p_clk_i,
  input  logic                     rst_n_i,
  input  logic                     nbf_valid_i,
  input  logic [gw_data_width-1:0] nbf_data_i,
  input  logic                     nbf_last_i,
  output logic                     nbf_ready_o,
  output logic                     cmd_valid_o,
  output gw_mem_cmd_s              cmd_o,
  input  logic                     cmd_ready_i,
  input  logic                     resp_valid_i,
  input  gw_mem_resp_s             resp_i,
  output logic                     resp_ready_o,
  output logic                     done_o
);

  logic [gw_credit_width-1:0] outstanding_q;
  logic [gw_addr_width-1:0]   word_cnt_q;
  logic                       last_sent_q;
  logic                       done_q;
  logic                       credit_ok;
  logic                       cmd_fire;
  logic                       resp_fire;

  // Nothing more after the last word
  assign credit_ok = ~last_sent_q & (outstanding_q < gw_credit_width'(gw_max_outstanding));

  // A word is taken only when its write leaves in the same cycle
  assign nbf_ready_o  = cmd_ready_i & credit_ok;
  assign cmd_valid_o  = nbf_valid_i & credit_ok;
  assign cmd_fire     = cmd_valid_o & cmd_ready_i;
  assign resp_fire    = resp_valid_i & resp_ready_o;
  assign resp_ready_o = 1'b1;
  assign done_o       = done_q;

  always_comb
  begin
    cmd_o.op   = gw_op_write;
    cmd_o.addr = gw_mem_base + word_cnt_q * gw_addr_width'(gw_word_bytes);
    cmd_o.data = nbf_data_i;
  end

  always_ff @(posedge p_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      outstanding_q <= '0;
      word_cnt_q    <= '0;
      last_sent_q   <= 1'b0;
      done_q        <= 1'b0;
    end
    else
    begin
      if (cmd_fire)
      begin
        word_cnt_q <= word_cnt_q + 1'b1;
        if (nbf_last_i)
        begin
          last_sent_q <= 1'b1;
        end
      end
      outstanding_q <= outstanding_q + gw_credit_width'(cmd_fire) -
                       gw_credit_width'(resp_fire);
      // Final write answered, nothing left in flight
      if (resp_fire && last_sent_q && outstanding_q == gw_credit_width'(1))
      begin
        done_q <= 1'b1;
      end
    end
  end

  a_credit_limit: assert property (@(posedge p_clk_i) disable iff (!rst_n_i)
    outstanding_q <= gw_credit_width'(gw_max_outstanding));

  a_resp_expected: assert property (@(posedge p_clk_i) disable iff (!rst_n_i)
    resp_valid_i |-> outstanding_q != '0 && resp_i.op == gw_op_write);

endmodule

// File: hw/gw_cfg_loader.sv
`timescale 1ns/1ps

module gw_cfg_loader
  import gw_boot_pkg::*;
  import gw_msg_pkg::*;
(
  input  logic         p_clk_i,
  input  logic         rst_n_i,
  output logic         cmd_valid_o,
  output gw_mem_cmd_s  cmd_o,
  input  logic         cmd_ready_i,
  input  logic         resp_valid_i,
  input  gw_mem_resp_s resp_i,
  output logic         resp_ready_o,
  output logic         cfg_done_o
);

  localparam int unsigned idx_width = $clog2(gw_cfg_entries);

  logic [idx_width-1:0]       idx_q;
  logic                       all_issued_q;
  logic [idx_width-1:0]       resp_cnt_q;
  logic [gw_credit_width-1:0] outstanding_q;
  logic                       cmd_valid_q;
  gw_mem_cmd_s                cmd_q;
  logic                       cfg_done_q;
  logic                       slot_free;
  logic                       load;
  logic                       resp_fire;

  assign slot_free = ~cmd_valid_q | cmd_ready_i;
  // Credit also covers the entry waiting in the output register
  assign load = slot_free & ~all_issued_q &
                (outstanding_q < gw_credit_width'(gw_max_outstanding));
  assign resp_fire = resp_valid_i & resp_ready_o;

  assign cmd_valid_o  = cmd_valid_q;
  assign cmd_o        = cmd_q;
  assign resp_ready_o = 1'b1;
  assign cfg_done_o   = cfg_done_q;

  always_ff @(posedge p_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      idx_q         <= '0;
      all_issued_q  <= 1'b0;
      resp_cnt_q    <= '0;
      outstanding_q <= '0;
      cmd_valid_q   <= 1'b0;
      cfg_done_q    <= 1'b0;
    end
    else
    begin
      if (slot_free)
      begin
        cmd_valid_q <= load;
      end
      if (load)
      begin
        if (idx_q == idx_width'(gw_cfg_entries - 1))
        begin
          all_issued_q <= 1'b1;
        end
        else
        begin
          idx_q <= idx_q + 1'b1;
        end
      end
      outstanding_q <= outstanding_q + gw_credit_width'(load) - gw_credit_width'(resp_fire);
      if (resp_fire)
      begin
        resp_cnt_q <= resp_cnt_q + 1'b1;
        // Last table entry answered
        if (resp_cnt_q == idx_width'(gw_cfg_entries - 1))
        begin
          cfg_done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge p_clk_i)
  begin
    if (load)
    begin
      cmd_q.op   <= gw_op_write;
      cmd_q.addr <= gw_cfg_base + gw_addr_width'(idx_q) * gw_addr_width'(gw_word_bytes);
      cmd_q.data <= gw_cfg_rom[idx_q];
    end
  end

  a_credit_limit: assert property (@(posedge p_clk_i) disable iff (!rst_n_i)
    outstanding_q <= gw_credit_width'(gw_max_outstanding));

  a_resp_expected: assert property (@(posedge p_clk_i) disable iff (!rst_n_i)
    resp_valid_i |-> outstanding_q != '0 && resp_i.op == gw_op_write);

endmodule

// File: hw/gw_skid_buffer.sv
`timescale 1ns/1ps

module gw_skid_buffer
#(
  parameter type payload_t = logic
)
(
  input  logic     p_clk_i,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  logic     out_valid_q;
  payload_t out_data_q;
  logic     skid_valid_q;
  payload_t skid_data_q;
  logic     out_free;
  logic     in_fire;

  // Output slot is empty or drains this cycle
  assign out_free   = out_ready_i | ~out_valid_q;
  assign in_ready_o = ~skid_valid_q;
  assign in_fire    = in_valid_i & ~skid_valid_q;

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

  always_ff @(posedge p_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end
    else if (out_free)
    begin
      out_valid_q  <= skid_valid_q | in_fire;
      skid_valid_q <= 1'b0;
    end
    else if (in_fire)
    begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge p_clk_i)
  begin
    if (out_free)
    begin
      out_data_q <= skid_valid_q ? skid_data_q : in_data_i;
    end
    // Stalled output, park the new item
    if (!out_free && in_fire)
    begin
      skid_data_q <= in_data_i;
    end
  end

  // Upstream keeps an offered item until it is taken
  a_in_stable: assert property (@(posedge p_clk_i) disable iff (!rst_n_i)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i));

endmodule

// File: hw/gw_msg_pkg.sv
package gw_msg_pkg;

  import gw_boot_pkg::*;

  typedef enum logic
  {
    gw_op_write = 1'b0,
    gw_op_read  = 1'b1
  } gw_mem_op_e;

  ////////////////////////////////////////////////////////////
  // Memory channel payloads

  // Command toward memory
  typedef struct packed
  {
    gw_mem_op_e               op;
    logic [gw_addr_width-1:0] addr;
    logic [gw_data_width-1:0] data;
  } gw_mem_cmd_s;

  // Response carries back the address it answers
  typedef struct packed
  {
    gw_mem_op_e               op;
    logic [gw_addr_width-1:0] addr;
  } gw_mem_resp_s;

endpackage

// File: hw/gw_boot_pkg.sv
package gw_boot_pkg;

  ////////////////////////////////////////////////////////////
  // Address map and widths

  localparam int unsigned gw_addr_width = 32;
  localparam int unsigned gw_data_width = 64;
  localparam int unsigned gw_word_bytes = 8;

  // Control registers and program memory
  localparam logic [gw_addr_width-1:0] gw_cfg_base = 32'h0020_0000;
  localparam logic [gw_addr_width-1:0] gw_mem_base = 32'h8000_0000;

  ////////////////////////////////////////////////////////////
  // Flow control

  localparam int unsigned gw_max_outstanding = 4;
  localparam int unsigned gw_credit_width = $clog2(gw_max_outstanding + 1);

  ////////////////////////////////////////////////////////////
  // Configuration table

  localparam int unsigned gw_cfg_entries = 8;

  // Freeze, clock dividers, core ids, then release of freeze
  localparam logic [gw_data_width-1:0] gw_cfg_rom [gw_cfg_entries] = '{
    64'h0000_0000_0000_0001,
    64'h0000_0000_0000_0004,
    64'h0000_0000_0000_0002,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0003,
    64'h0000_0000_8000_0000,
    64'h0000_00ff_0000_0010,
    64'h0000_0000_0000_0000
  };

endpackage
